// ==== logic/usbPePkg.sv ====
package usbPePkg;

    // ============================================================
    // Packet data
    // ============================================================

    // One byte on the receive stream
    typedef logic [7:0] byteT;

    // PID code, low nibble of the PID byte
    typedef logic [3:0] pidT;

    // Endpoint number as carried in a token
    typedef logic [3:0] epFieldT;

    // Token packet is PID, address/endpoint and endpoint/CRC5
    localparam int TOKEN_BYTES = 3;

    // OUT token, host to device
    localparam pidT PID_OUT = 4'b0001;

    // ============================================================
    // Endpoint FIFOs
    // ============================================================

    // Data endpoints, numbered from zero
    localparam int EP_COUNT = 4;
    typedef logic [1:0] epSelT;

    // Bytes per endpoint FIFO
    localparam int FIFO_DEPTH = 8;

    // Extra top bit tells full from empty
    typedef logic [3:0] fifoPtrT;

    // ============================================================
    // Packet-wait timer
    // ============================================================

    // 48 MHz clocks per 12 MHz bit time
    localparam int CLK_PER_BIT = 4;

    // Silent bit times before a transaction is abandoned
    localparam int PACKET_TIMEOUT_BITS = 18;
    typedef logic [4:0] bitCountT;

    // Transaction phase of the receive side
    typedef enum logic {
        PH_AWAIT_TOKEN,
        PH_DATA
    } rxPhaseT;

endpackage

// ==== logic/tokenCapture.sv ====
module tokenCapture (
    input  logic              clk48_i,
    input  logic              rstN_i,
    input  logic              byteStrobe_i,
    input  usbPePkg::byteT    byteData_i,
    input  logic              clear_i,
    output logic              tokenValid_o,
    output usbPePkg::pidT     tokenPid_o,
    output usbPePkg::epFieldT tokenEp_o
);
    import usbPePkg::*;

    // Counts 0 up to TOKEN_BYTES
    typedef logic [$clog2(TOKEN_BYTES + 1) - 1:0] byteCountT;

    byteT      byteBuf [TOKEN_BYTES];
    byteCountT byteCount;
    logic      bufFull;
    logic      tooLong;
    logic      pidGood;

    assign bufFull = byteCount == byteCountT'(TOKEN_BYTES);

    // Byte buffer, filled in arrival order
    always_ff @(posedge clk48_i) begin
        if (byteStrobe_i && !bufFull) begin
            byteBuf[byteCount] <= byteData_i;
        end
    end

    // Byte counter and length check
    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            byteCount <= '0;
            tooLong   <= 1'b0;
        end else if (clear_i) begin
            // Ready for the next candidate packet
            byteCount <= '0;
            tooLong   <= 1'b0;
        end else if (byteStrobe_i) begin
            if (bufFull) begin
                // Longer than any token, never valid
                tooLong <= 1'b1;
            end else begin
                byteCount <= byteCount + 1'b1;
            end
        end
    end

    // Upper nibble carries the complement of the code
    assign pidGood = byteBuf[0][3:0] == ~byteBuf[0][7:4];

    assign tokenValid_o = bufFull && !tooLong && pidGood;
    assign tokenPid_o   = byteBuf[0][3:0];

    // Endpoint field straddles bytes 1 and 2
    // Bit 0 is byte 1 bit 7, bits 3..1 are byte 2 bits 2..0
    assign tokenEp_o = {byteBuf[2][2:0], byteBuf[1][7]};

endmodule

// ==== logic/rxController.sv ====
module rxController (
    input  logic              clk48_i,
    input  logic              rstN_i,
    input  usbPePkg::byteT    rxData_i,
    input  logic              rxDataValid_i,
    input  logic              rxIsLastByte_i,
    input  logic              keepPacket_i,
    output logic              rxAcceptNewData_o,
    output logic              transOk_o,
    output logic              transErr_o,
    output logic              capStrobe_o,
    output logic              capClear_o,
    input  logic              tokenValid_i,
    input  usbPePkg::pidT     tokenPid_i,
    input  usbPePkg::epFieldT tokenEp_i,
    output logic              wrEn_o,
    output usbPePkg::byteT    wrData_o,
    output usbPePkg::epSelT   epSel_o,
    output logic              commit_o,
    output logic              rollback_o,
    input  logic              fifoFull_i,
    output logic              timerRun_o,
    input  logic              timeout_i
);
    import usbPePkg::*;

    rxPhaseT phase;
    logic    done;
    logic    failed;
    logic    firstByte;
    logic    handshake;
    logic    inData;
    logic    dataDone;
    logic    tokenAccepted;

    // ============================================================
    // Receive handshake
    // ============================================================

    // Done cycle blocks exactly one byte slot after each packet
    assign rxAcceptNewData_o = !done;
    assign handshake         = rxDataValid_i && rxAcceptNewData_o;
    assign inData            = phase == PH_DATA;

    // Token phase feeds the capture buffer
    assign capStrobe_o = handshake && !inData;
    assign capClear_o  = done;

    // Data phase skips the data PID, overflow bytes are dropped
    assign wrEn_o   = handshake && inData && !firstByte && !fifoFull_i;
    assign wrData_o = rxData_i;

    // ============================================================
    // Packet decision in the done cycle
    // ============================================================

    // Only OUT to an existing data endpoint opens a transaction
    assign tokenAccepted = tokenValid_i && !failed && tokenPid_i == PID_OUT
                           && tokenEp_i < epFieldT'(EP_COUNT);

    assign dataDone   = done && inData;
    assign commit_o   = dataDone && !failed;
    // Timeout also drops anything written so far
    assign rollback_o = (dataDone && failed) || (inData && timeout_i && !done);
    assign transOk_o  = commit_o;
    assign transErr_o = dataDone && failed;

    // Timer watches the gap between token and data
    assign timerRun_o = inData;

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            phase     <= PH_AWAIT_TOKEN;
            done      <= 1'b0;
            failed    <= 1'b0;
            firstByte <= 1'b1;
            epSel_o   <= '0;
        end else begin
            done <= handshake && rxIsLastByte_i;

            // Failure sticks until the done cycle
            if (done) begin
                failed <= 1'b0;
            end else if (handshake) begin
                if (rxIsLastByte_i && !keepPacket_i) begin
                    failed <= 1'b1;
                end
                if (inData && !firstByte && fifoFull_i) begin
                    failed <= 1'b1;
                end
            end

            // Marks the PID byte of the next packet
            if (done) begin
                firstByte <= 1'b1;
            end else if (handshake) begin
                firstByte <= 1'b0;
            end

            case (phase)
                PH_AWAIT_TOKEN: begin
                    if (done && tokenAccepted) begin
                        phase   <= PH_DATA;
                        epSel_o <= epSelT'(tokenEp_i);
                    end
                end
                PH_DATA: begin
                    // Any data packet or silence closes the transaction
                    if (done || timeout_i) begin
                        phase <= PH_AWAIT_TOKEN;
                    end
                end
                default: phase <= PH_AWAIT_TOKEN;
            endcase
        end
    end

endmodule

// ==== logic/epFifoBank.sv ====
module epFifoBank (
    input  logic                                   clk48_i,
    input  logic                                   rstN_i,
    input  logic                                   wrEn_i,
    input  usbPePkg::byteT                         wrData_i,
    input  usbPePkg::epSelT                        epSel_i,
    input  logic                                   commit_i,
    input  logic                                   rollback_i,
    output logic                                   fifoFull_o,
    input  logic [usbPePkg::EP_COUNT-1:0]          epPop_i,
    output logic [usbPePkg::EP_COUNT-1:0]          epDataAvailable_o,
    output usbPePkg::byteT [usbPePkg::EP_COUNT-1:0] epData_o
);
    import usbPePkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    byteT    mem [EP_COUNT][FIFO_DEPTH];
    // Read side
    fifoPtrT rdPtr [EP_COUNT];
    // Speculative write side, moves with every stored byte
    fifoPtrT wrPtr [EP_COUNT];
    // Committed write side, end of the last good packet
    fifoPtrT cmPtr [EP_COUNT];
    logic    wrAllowed;

    // Fullness counts uncommitted bytes too
    assign fifoFull_o = fifoPtrT'(wrPtr[epSel_i] - rdPtr[epSel_i]) == fifoPtrT'(FIFO_DEPTH);
    assign wrAllowed  = wrEn_i && !fifoFull_o;

    // Consumers only ever see committed bytes
    always_comb begin
        for (int i = 0; i < EP_COUNT; i++) begin
            epDataAvailable_o[i] = cmPtr[i] != rdPtr[i];
            epData_o[i]          = mem[i][rdPtr[i][ADDR_W-1:0]];
        end
    end

    // ============================================================
    // Storage
    // ============================================================

    always_ff @(posedge clk48_i) begin
        if (wrAllowed) begin
            mem[epSel_i][wrPtr[epSel_i][ADDR_W-1:0]] <= wrData_i;
        end
    end

    // ============================================================
    // Pointers
    // ============================================================

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < EP_COUNT; i++) begin
                rdPtr[i] <= '0;
                wrPtr[i] <= '0;
                cmPtr[i] <= '0;
            end
        end else begin
            // Pops run on every endpoint independently
            for (int i = 0; i < EP_COUNT; i++) begin
                if (epPop_i[i] && epDataAvailable_o[i]) begin
                    rdPtr[i] <= rdPtr[i] + 1'b1;
                end
            end

            if (wrAllowed) begin
                wrPtr[epSel_i] <= wrPtr[epSel_i] + 1'b1;
            end

            // Whole packet becomes visible at once
            if (commit_i) begin
                cmPtr[epSel_i] <= wrPtr[epSel_i];
            end else if (rollback_i) begin
                // Forget the failed packet
                wrPtr[epSel_i] <= cmPtr[epSel_i];
            end
        end
    end

endmodule

// ==== logic/packetTimer.sv ====
module packetTimer (
    input  logic clk48_i,
    input  logic rstN_i,
    input  logic run_i,
    input  logic lineActive_i,
    output logic timeout_o
);
    import usbPePkg::*;

    typedef logic [$clog2(CLK_PER_BIT) - 1:0] divCountT;

    divCountT divCount;
    bitCountT bitCount;
    logic     bitTick;
    logic     restart;

    // One tick per 12 MHz bit time, phase is free running
    assign bitTick = divCount == divCountT'(CLK_PER_BIT - 1);

    // Line activity or an idle phase holds the count at zero
    assign restart = !run_i || lineActive_i;

    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            divCount <= '0;
        end else if (bitTick) begin
            divCount <= '0;
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    // Saturates at the limit so the pulse fires only once
    always_ff @(posedge clk48_i) begin
        if (!rstN_i) begin
            bitCount <= '0;
        end else if (restart) begin
            bitCount <= '0;
        end else if (bitTick && bitCount != bitCountT'(PACKET_TIMEOUT_BITS)) begin
            bitCount <= bitCount + 1'b1;
        end
    end

    // Fires on the tick that completes the silent interval
    assign timeout_o = !restart && bitTick
                       && bitCount == bitCountT'(PACKET_TIMEOUT_BITS - 1);

endmodule

// ==== logic/usbPe.sv ====
module usbPe (
    input  logic                                   clk48_i,
    input  logic                                   rstN_i,
    input  usbPePkg::byteT                         rxData_i,
    input  logic                                   rxDataValid_i,
    input  logic                                   rxIsLastByte_i,
    input  logic                                   keepPacket_i,
    input  logic                                   rxLineActive_i,
    output logic                                   rxAcceptNewData_o,
    output logic                                   transOk_o,
    output logic                                   transErr_o,
    output logic                                   timeout_o,
    input  logic [usbPePkg::EP_COUNT-1:0]          epPop_i,
    output logic [usbPePkg::EP_COUNT-1:0]          epDataAvailable_o,
    output usbPePkg::byteT [usbPePkg::EP_COUNT-1:0] epData_o
);
    import usbPePkg::*;

    // Token capture
    logic    capStrobe;
    logic    capClear;
    logic    tokenValid;
    pidT     tokenPid;
    epFieldT tokenEp;

    // FIFO write side
    logic    wrEn;
    byteT    wrData;
    epSelT   epSel;
    logic    commit;
    logic    rollback;
    logic    fifoFull;

    // Packet-wait timer
    logic    timerRun;

    tokenCapture u_tokenCapture (
        .clk48_i      (clk48_i),
        .rstN_i       (rstN_i),
        .byteStrobe_i (capStrobe),
        .byteData_i   (rxData_i),
        .clear_i      (capClear),
        .tokenValid_o (tokenValid),
        .tokenPid_o   (tokenPid),
        .tokenEp_o    (tokenEp)
    );

    rxController u_rxController (
        .clk48_i           (clk48_i),
        .rstN_i            (rstN_i),
        .rxData_i          (rxData_i),
        .rxDataValid_i     (rxDataValid_i),
        .rxIsLastByte_i    (rxIsLastByte_i),
        .keepPacket_i      (keepPacket_i),
        .rxAcceptNewData_o (rxAcceptNewData_o),
        .transOk_o         (transOk_o),
        .transErr_o        (transErr_o),
        .capStrobe_o       (capStrobe),
        .capClear_o        (capClear),
        .tokenValid_i      (tokenValid),
        .tokenPid_i        (tokenPid),
        .tokenEp_i         (tokenEp),
        .wrEn_o            (wrEn),
        .wrData_o          (wrData),
        .epSel_o           (epSel),
        .commit_o          (commit),
        .rollback_o        (rollback),
        .fifoFull_i        (fifoFull),
        .timerRun_o        (timerRun),
        .timeout_i         (timeout_o)
    );

    epFifoBank u_epFifoBank (
        .clk48_i           (clk48_i),
        .rstN_i            (rstN_i),
        .wrEn_i            (wrEn),
        .wrData_i          (wrData),
        .epSel_i           (epSel),
        .commit_i          (commit),
        .rollback_i        (rollback),
        .fifoFull_o        (fifoFull),
        .epPop_i           (epPop_i),
        .epDataAvailable_o (epDataAvailable_o),
        .epData_o          (epData_o)
    );

    packetTimer u_packetTimer (
        .clk48_i      (clk48_i),
        .rstN_i       (rstN_i),
        .run_i        (timerRun),
        .lineActive_i (rxLineActive_i),
        .timeout_o    (timeout_o)
    );

endmodule

// ==== verification/usbPe_properties.sv ====
module usbPe_properties (
    input logic                          clk48_i,
    input logic                          rstN_i,
    input logic                          rxDataValid_i,
    input logic                          rxIsLastByte_i,
    input logic                          rxAcceptNewData_o,
    input logic                          transOk_o,
    input logic                          transErr_o,
    input logic [usbPePkg::EP_COUNT-1:0] epDataAvailable_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // A data packet ends either good or failed, never both
    resultExclusive: assert property (
        @(posedge clk48_i) disable iff (!rstN_i) !(transOk_o && transErr_o)
    ) else $error("transOk_o and transErr_o high in the same cycle");

    // Done cycle follows every last-byte handshake
    doneCycleBlocks: assert property (
        @(posedge clk48_i) disable iff (!rstN_i)
        (rxDataValid_i && rxAcceptNewData_o && rxIsLastByte_i) |=> !rxAcceptNewData_o
    ) else $error("rxAcceptNewData_o high right after the last byte");

    // Pointers are cleared one edge into reset
    emptyInReset: assert property (
        @(posedge clk48_i) !rstN_i |=> (rstN_i || epDataAvailable_o == '0)
    ) else $error("epDataAvailable_o set while reset is applied");

endmodule

bind usbPe usbPe_properties u_props (
    .clk48_i           (clk48_i),
    .rstN_i            (rstN_i),
    .rxDataValid_i     (rxDataValid_i),
    .rxIsLastByte_i    (rxIsLastByte_i),
    .rxAcceptNewData_o (rxAcceptNewData_o),
    .transOk_o         (transOk_o),
    .transErr_o        (transErr_o),
    .epDataAvailable_o (epDataAvailable_o)
);

// ==== verification/tb_usbPe.sv ====
module tb_usbPe;
    timeunit 1ns;
    timeprecision 100ps;

    import usbPePkg::*;

    // DATA0 with its complement nibble, IN token code
    localparam byteT DATA0_PID    = 8'hC3;
    localparam pidT  PID_IN       = 4'b1001;
    localparam int   ACCEPT_LIMIT = 20;
    localparam int   TIMER_LIMIT  = 100;

    logic                  clk48;
    logic                  rstN_i;
    byteT                  rxData_i;
    logic                  rxDataValid_i;
    logic                  rxIsLastByte_i;
    logic                  keepPacket_i;
    logic                  rxLineActive_i;
    logic                  rxAcceptNewData_o;
    logic                  transOk_o;
    logic                  transErr_o;
    logic                  timeout_o;
    logic [EP_COUNT-1:0]   epPop_i;
    logic [EP_COUNT-1:0]   epDataAvailable_o;
    byteT [EP_COUNT-1:0]   epData_o;

    // Expected contents per endpoint
    byteT        expQ [EP_COUNT][$];
    byteT        payload [$];
    logic [31:0] lfsrState = 32'hc2e4dff3;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          okPulses = 0;
    int          errPulses = 0;
    int          timeoutPulses = 0;

    usbPe u_dut (
        .clk48_i           (clk48),
        .rstN_i            (rstN_i),
        .rxData_i          (rxData_i),
        .rxDataValid_i     (rxDataValid_i),
        .rxIsLastByte_i    (rxIsLastByte_i),
        .keepPacket_i      (keepPacket_i),
        .rxLineActive_i    (rxLineActive_i),
        .rxAcceptNewData_o (rxAcceptNewData_o),
        .transOk_o         (transOk_o),
        .transErr_o        (transErr_o),
        .timeout_o         (timeout_o),
        .epPop_i           (epPop_i),
        .epDataAvailable_o (epDataAvailable_o),
        .epData_o          (epData_o)
    );

    // 250 MHz sim clock, only the cycle count matters
    initial begin
        clk48 = 1'b0;
        forever #2 clk48 = ~clk48;
    end

    // Strobes counted mid-cycle where they are stable
    always @(negedge clk48) begin
        if (rstN_i) begin
            if (transOk_o) okPulses++;
            if (transErr_o) errPulses++;
            if (timeout_o) timeoutPulses++;
        end
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic byteT randomByte();
        byteT b;
        for (int i = 0; i < 8; i++) begin
            lfsrState = lfsrStep(lfsrState);
            b[i] = lfsrState[0];
        end
        return b;
    endfunction

    function automatic byteT pidByte(input pidT code);
        return {~code, code};
    endfunction

    function automatic logic [EP_COUNT-1:0] expectedAvail();
        logic [EP_COUNT-1:0] v;
        for (int i = 0; i < EP_COUNT; i++) begin
            v[i] = expQ[i].size() != 0;
        end
        return v;
    endfunction

    // One byte per handshake, waits out the done cycle
    task automatic sendPacket(input byteT bytes[$], input logic keep);
        int waitCycles;
        @(posedge clk48);
        foreach (bytes[i]) begin
            rxData_i       <= bytes[i];
            rxDataValid_i  <= 1'b1;
            rxIsLastByte_i <= (i == bytes.size() - 1);
            keepPacket_i   <= keep;
            rxLineActive_i <= 1'b1;
            waitCycles = 0;
            @(negedge clk48);
            while (!rxAcceptNewData_o && waitCycles < ACCEPT_LIMIT) begin
                @(negedge clk48);
                waitCycles++;
            end
            if (!rxAcceptNewData_o) begin
                $display("Byte %0d of a packet was never accepted by the DUT", i);
                errorCount++;
            end
            @(posedge clk48);
        end
        rxDataValid_i  <= 1'b0;
        rxIsLastByte_i <= 1'b0;
        rxLineActive_i <= 1'b0;
    endtask

    // Address and CRC5 bits carry filler
    task automatic sendToken(input byteT pid, input epFieldT ep);
        byteT bytes[$];
        bytes.push_back(pid);
        bytes.push_back({ep[0], 7'h2a});
        bytes.push_back({5'h15, ep[3:1]});
        sendPacket(bytes, 1'b1);
    endtask

    task automatic sendData(input int n, input logic keep);
        byteT bytes[$];
        byteT b;
        payload.delete();
        bytes.push_back(DATA0_PID);
        repeat (n) begin
            b = randomByte();
            payload.push_back(b);
            bytes.push_back(b);
        end
        sendPacket(bytes, keep);
    endtask

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic compareByte(input string name, input byteT got, input byteT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compareVec(input string name, input logic [EP_COUNT-1:0] got,
                              input logic [EP_COUNT-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compareCount(input string name, input int got, input int exp);
        checkCount++;
        if (got != exp) begin
            errorCount++;
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Done cycle, then commit visible one cycle later
    task automatic checkDone(input logic expOk, input logic expErr);
        @(negedge clk48);
        compareBit("rxAcceptNewData_o", rxAcceptNewData_o, 1'b0);
        compareBit("transOk_o", transOk_o, expOk);
        compareBit("transErr_o", transErr_o, expErr);
        @(posedge clk48);
        @(negedge clk48);
        compareVec("epDataAvailable_o", epDataAvailable_o, expectedAvail());
    endtask

    task automatic drainEndpoint(input int ep);
        logic [EP_COUNT-1:0] mask;
        mask = '0;
        mask[ep] = 1'b1;
        while (expQ[ep].size() != 0) begin
            @(negedge clk48);
            compareBit($sformatf("epDataAvailable_o[%0d]", ep), epDataAvailable_o[ep], 1'b1);
            compareByte($sformatf("epData_o[%0d]", ep), epData_o[ep], expQ[ep].pop_front());
            @(posedge clk48);
            epPop_i <= mask;
            @(posedge clk48);
            epPop_i <= '0;
        end
        @(negedge clk48);
        compareVec("epDataAvailable_o", epDataAvailable_o, expectedAvail());
    endtask

    // OUT token and one data packet, result given by the caller
    task automatic outTransfer(input epFieldT ep, input int n, input logic keep,
                               input logic expOk);
        int okBefore;
        int errBefore;
        okBefore = okPulses;
        errBefore = errPulses;
        sendToken(pidByte(PID_OUT), ep);
        checkDone(1'b0, 1'b0);
        sendData(n, keep);
        if (expOk) begin
            foreach (payload[i]) expQ[int'(ep)].push_back(payload[i]);
        end
        checkDone(expOk, !expOk);
        compareCount("transOk_o pulses", okPulses - okBefore, expOk ? 1 : 0);
        compareCount("transErr_o pulses", errPulses - errBefore, expOk ? 0 : 1);
    endtask

    task automatic rejectedToken(input byteT pid, input epFieldT ep);
        int okBefore;
        int errBefore;
        okBefore = okPulses;
        errBefore = errPulses;
        sendToken(pid, ep);
        checkDone(1'b0, 1'b0);
        // Stays in token phase, so this is just another candidate
        sendData(2, 1'b1);
        checkDone(1'b0, 1'b0);
        compareCount("transOk_o pulses", okPulses - okBefore, 0);
        compareCount("transErr_o pulses", errPulses - errBefore, 0);
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("%s finished, %0d errors so far", name, errorCount);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic testTimeout();
        int n;
        int okBefore;
        int errBefore;
        int toBefore;
        okBefore = okPulses;
        errBefore = errPulses;
        toBefore = timeoutPulses;
        sendToken(pidByte(PID_OUT), 4'd3);
        // Cycle 0 is the done cycle of the token
        n = 0;
        @(negedge clk48);
        while (!timeout_o && n < TIMER_LIMIT) begin
            @(negedge clk48);
            n++;
        end
        if (!timeout_o) begin
            $display("timeout_o never pulsed after a token with a silent line");
            errorCount++;
        end else if (n < 69 || n > 72) begin
            errorCount++;
            $display("ERROR %0t timeout_o delay got %0d expected 69 to 72", $time, n);
        end
        repeat (2) @(posedge clk48);
        // Back in token phase, six bytes are too long for a token
        sendData(5, 1'b1);
        checkDone(1'b0, 1'b0);
        compareCount("timeout_o pulses", timeoutPulses - toBefore, 1);
        compareCount("transOk_o pulses", okPulses - okBefore, 0);
        compareCount("transErr_o pulses", errPulses - errBefore, 0);
    endtask

    initial begin
        rstN_i         <= 1'b0;
        rxData_i       <= '0;
        rxDataValid_i  <= 1'b0;
        rxIsLastByte_i <= 1'b0;
        keepPacket_i   <= 1'b0;
        rxLineActive_i <= 1'b0;
        epPop_i        <= '0;
        repeat (5) @(posedge clk48);
        rstN_i <= 1'b1;

        // Idle state after reset
        @(negedge clk48);
        compareBit("rxAcceptNewData_o", rxAcceptNewData_o, 1'b1);
        compareBit("transOk_o", transOk_o, 1'b0);
        compareBit("transErr_o", transErr_o, 1'b0);
        compareBit("timeout_o", timeout_o, 1'b0);
        compareVec("epDataAvailable_o", epDataAvailable_o, '0);
        finishTest("Reset state");

        outTransfer(4'd2, 5, 1'b1, 1'b1);
        drainEndpoint(2);
        finishTest("Good packet to endpoint 2");

        outTransfer(4'd2, 5, 1'b0, 1'b0);
        finishTest("Withdrawn keepPacket_i");

        rejectedToken(pidByte(PID_OUT), 4'd5);
        rejectedToken(pidByte(PID_IN), 4'd1);
        rejectedToken(8'h11, 4'd1);
        finishTest("Rejected tokens");

        outTransfer(4'd1, 2, 1'b1, 1'b1);
        outTransfer(4'd1, FIFO_DEPTH + 2, 1'b1, 1'b0);
        drainEndpoint(1);
        finishTest("FIFO overflow");

        testTimeout();
        finishTest("Packet-wait timeout");

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/usbPePkg.sv
logic/tokenCapture.sv
logic/rxController.sv
logic/epFifoBank.sv
logic/packetTimer.sv
logic/usbPe.sv
verification/usbPe_properties.sv
verification/tb_usbPe.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the USB receive engine testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
    --top-module tb_usbPe --Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

if grep -qx "No errors" sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
